// File: rtl/lcd_pkg.sv
package lcd_pkg;

	// timing base
	localparam int CYC_PER_US = 15;	// clock cycles per microsecond

	localparam int T_POWERUP_US = 500;	// wait after reset
	localparam int T_CMD_US = 50;	// normal command slot
	localparam int T_CLEAR_US = 200;	// clear needs the long slot
	localparam int T_INIT_E_US = 10;	// enable width during init
	localparam int T_ENTRY_US = 100;	// wait after entry mode set
	localparam int T_E_SETUP_US = 1;	// e low before the pulse
	localparam int T_E_HIGH_US = 13;	// e pulse width

	// display geometry
	localparam int COLS = 16;
	localparam int ROWS = 2;
	localparam int COL_W = $clog2(COLS);
	localparam int ROW_W = (ROWS > 1) ? $clog2(ROWS) : 1;
	typedef logic [COL_W-1:0] col_t;
	typedef logic [ROW_W-1:0] row_t;
	localparam col_t LAST_COL = col_t'(COLS - 1);
	localparam row_t LAST_ROW = row_t'(ROWS - 1);
	localparam logic [6:0] LINE2_ADDR = 7'h40;	// ddram start of line two

	// command bytes
	localparam logic [7:0] CMD_CLEAR = 8'h01;
	localparam logic [7:0] CMD_SET_ADDR = 8'h80;	// address goes in the low bits

	// command queue
	localparam int FIFO_DEPTH = 16;
	localparam int FIFO_AW = $clog2(FIFO_DEPTH);
	typedef logic [FIFO_AW:0] fifo_cnt_t;
	localparam fifo_cnt_t FIFO_FULL = fifo_cnt_t'(FIFO_DEPTH);

	// shared cycle counter of the bus driver
	localparam int CNT_W = $clog2(T_POWERUP_US * CYC_PER_US + 1);
	typedef logic [CNT_W-1:0] cnt_t;
	localparam cnt_t POWERUP_CYC = cnt_t'(T_POWERUP_US * CYC_PER_US);
	localparam cnt_t CMD_CYC = cnt_t'(T_CMD_US * CYC_PER_US);
	localparam cnt_t CLEAR_CYC = cnt_t'(T_CLEAR_US * CYC_PER_US);
	localparam cnt_t ENTRY_WAIT_CYC = cnt_t'(T_ENTRY_US * CYC_PER_US);
	localparam cnt_t INIT_E_CYC = cnt_t'(T_INIT_E_US * CYC_PER_US);
	localparam cnt_t E_RISE_CYC = cnt_t'(T_E_SETUP_US * CYC_PER_US);
	localparam cnt_t E_FALL_CYC = cnt_t'((T_E_SETUP_US + T_E_HIGH_US) * CYC_PER_US);

	// one queued display command
	typedef struct packed {
		logic rs;	// 1 = character, 0 = command
		logic [7:0] data;
		logic set_addr;	// address command goes first
		logic [6:0] addr;
	} lcd_cmd_t;

endpackage

// File: rtl/lcd_cmd_if.sv
`timescale 1ns/1ps

// head of the command queue as seen by the bus driver
interface lcd_cmd_if;

	logic valid;	// queue not empty
	lcd_pkg::lcd_cmd_t entry;	// head entry
	logic take;	// driver removes the head
	logic ready_in;	// driver idle and initialized

	modport source (
		output valid,
		output entry,
		input take,
		input ready_in
	);

	modport sink (
		input valid,
		input entry,
		output take,
		output ready_in
	);

endinterface

// File: rtl/lcd_cursor_tracker.sv
`timescale 1ns/1ps

module lcd_cursor_tracker (
	input logic clk,
	input logic rst,
	input logic char_valid,
	input logic [7:0] char_code,
	input logic clear_valid,
	output logic push,
	output lcd_pkg::lcd_cmd_t push_entry
);

	lcd_pkg::col_t col;	// column of the next character
	lcd_pkg::row_t row;	// row of the next character
	logic need_addr;	// cursor wrapped, display address is stale
	logic at_line_end;
	logic [6:0] line_addr;

	assign at_line_end = (col == lcd_pkg::LAST_COL);

	// start address of the current row
	always_comb begin
		if (row == '0) begin
			line_addr = 7'h00;
		end else begin
			line_addr = lcd_pkg::LINE2_ADDR;
		end
	end

	// cursor and strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			push <= 1'b0;
			col <= '0;
			row <= '0;
			need_addr <= 1'b0;
		end else begin
			push <= char_valid | clear_valid;
			if (clear_valid) begin	// clear wins over a character
				col <= '0;
				row <= '0;
				need_addr <= 1'b0;	// display homes itself on clear
			end else if (char_valid) begin
				need_addr <= at_line_end;
				if (at_line_end) begin
					col <= '0;
					if (row == lcd_pkg::LAST_ROW) begin
						row <= '0;
					end else begin
						row <= row + 1'b1;
					end
				end else begin
					col <= col + 1'b1;
				end
			end
		end
	end

	// entry payload, qualified by push
	always_ff @(posedge clk) begin
		if (clear_valid) begin
			push_entry.rs <= 1'b0;
			push_entry.data <= lcd_pkg::CMD_CLEAR;
			push_entry.set_addr <= 1'b0;
			push_entry.addr <= '0;
		end else if (char_valid) begin
			push_entry.rs <= 1'b1;
			push_entry.data <= char_code;
			push_entry.set_addr <= need_addr;	// first char after a wrap
			push_entry.addr <= line_addr;
		end
	end

endmodule

// File: rtl/lcd_cmd_fifo.sv
`timescale 1ns/1ps

module lcd_cmd_fifo (
	input logic clk,
	input logic rst,
	input logic push,
	input lcd_pkg::lcd_cmd_t push_entry,
	lcd_cmd_if.source cmd,
	output logic overflow
);

	lcd_pkg::lcd_cmd_t mem [lcd_pkg::FIFO_DEPTH];
	logic [lcd_pkg::FIFO_AW-1:0] wr_ptr;
	logic [lcd_pkg::FIFO_AW-1:0] rd_ptr;
	lcd_pkg::fifo_cnt_t count;
	logic full;
	logic do_push;
	logic do_pop;

	assign full = (count == lcd_pkg::FIFO_FULL);
	assign do_push = push && !full;	// no back-pressure, drop when full
	assign do_pop = cmd.take && cmd.ready_in && cmd.valid;

	assign cmd.valid = (count != '0);
	assign cmd.entry = mem[rd_ptr];	// head

	// storage
	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr] <= push_entry;
		end
	end

	// pointers wrap on their own, depth is a power of two
	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			overflow <= 1'b0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
			case ({do_push, do_pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			if (push && full) begin
				overflow <= 1'b1;	// sticky until reset
			end
		end
	end

endmodule

// File: rtl/lcd_bus_driver.sv
`timescale 1ns/1ps

module lcd_bus_driver (
	input logic clk,
	input logic rst,
	input logic [6:0] disp_mode,	// lines, font, display, cursor, blink, inc, shift
	lcd_cmd_if.sink cmd,
	output logic lcd_e,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic [7:0] lcd_data,
	output logic ready
);

	typedef enum logic [1:0] {
		ST_POWERUP,
		ST_INIT,
		ST_IDLE,
		ST_XFER
	} state_t;

	state_t state;
	lcd_pkg::cnt_t cnt;	// shared by every phase
	logic [1:0] init_step;
	logic [7:0] init_byte;
	lcd_pkg::cnt_t init_wait;
	lcd_pkg::cnt_t step_len;
	lcd_pkg::lcd_cmd_t cur;	// entry being played
	logic addr_phase;	// address command still to go
	logic xfer_rs;
	logic [7:0] xfer_byte;
	lcd_pkg::cnt_t slot_len;
	logic take;

	assign lcd_rw = 1'b0;	// write only

	assign cmd.ready_in = (state == ST_IDLE);
	assign take = cmd.valid && (state == ST_IDLE);
	assign cmd.take = take;

	// power-up command table
	always_comb begin
		case (init_step)
			2'd0: begin	// function set
				init_byte = {4'b0011, disp_mode[6:5], 2'b00};
				init_wait = lcd_pkg::CMD_CYC;
			end
			2'd1: begin	// display on/off control
				init_byte = {5'b00001, disp_mode[4:2]};
				init_wait = lcd_pkg::CMD_CYC;
			end
			2'd2: begin
				init_byte = lcd_pkg::CMD_CLEAR;
				init_wait = lcd_pkg::CLEAR_CYC;
			end
			default: begin	// entry mode set
				init_byte = {6'b000001, disp_mode[1:0]};
				init_wait = lcd_pkg::ENTRY_WAIT_CYC;
			end
		endcase
		step_len = lcd_pkg::INIT_E_CYC + init_wait;
	end

	// byte on the bus during a transfer
	always_comb begin
		if (addr_phase) begin
			xfer_rs = 1'b0;
			xfer_byte = lcd_pkg::CMD_SET_ADDR | {1'b0, cur.addr};
		end else begin
			xfer_rs = cur.rs;
			xfer_byte = cur.data;
		end
		if (!xfer_rs && (xfer_byte == lcd_pkg::CMD_CLEAR)) begin
			slot_len = lcd_pkg::CLEAR_CYC;	// clear is slow
		end else begin
			slot_len = lcd_pkg::CMD_CYC;
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			cur <= cmd.entry;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= ST_POWERUP;
			cnt <= '0;
			init_step <= '0;
			addr_phase <= 1'b0;
			lcd_e <= 1'b0;
			lcd_rs <= 1'b0;
			lcd_data <= '0;
			ready <= 1'b0;
		end else begin
			case (state)
				ST_POWERUP: begin
					if (cnt == lcd_pkg::POWERUP_CYC - 1'b1) begin
						cnt <= '0;
						state <= ST_INIT;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_INIT: begin
					lcd_rs <= 1'b0;
					lcd_data <= init_byte;
					lcd_e <= (cnt < lcd_pkg::INIT_E_CYC);	// e leads the wait
					if (cnt == step_len - 1'b1) begin
						cnt <= '0;
						init_step <= init_step + 1'b1;
						if (init_step == 2'd3) begin
							state <= ST_IDLE;
							ready <= 1'b1;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
				ST_IDLE: begin
					lcd_e <= 1'b0;
					if (take) begin
						cnt <= '0;
						addr_phase <= cmd.entry.set_addr;
						state <= ST_XFER;
					end
				end
				default: begin	// ST_XFER
					lcd_rs <= xfer_rs;
					lcd_data <= xfer_byte;
					lcd_e <= (cnt >= lcd_pkg::E_RISE_CYC) && (cnt < lcd_pkg::E_FALL_CYC);
					if (cnt == slot_len - 1'b1) begin
						cnt <= '0;
						if (addr_phase) begin
							addr_phase <= 1'b0;	// now the byte itself
						end else begin
							state <= ST_IDLE;
						end
					end else begin
						cnt <= cnt + 1'b1;
					end
				end
			endcase
		end
	end

endmodule

// File: rtl/lcd_text_top.sv
`timescale 1ns/1ps

module lcd_text_top (
	input logic clk,
	input logic rst,
	input logic char_valid,
	input logic [7:0] char_code,
	input logic clear_valid,
	input logic [6:0] disp_mode,
	output logic lcd_e,
	output logic lcd_rs,
	output logic lcd_rw,
	output logic [7:0] lcd_data,
	output logic ready,
	output logic overflow
);

	logic push;
	lcd_pkg::lcd_cmd_t push_entry;

	lcd_cmd_if cmd_bus ();	// queue head to driver

	lcd_cursor_tracker tracker0 (
		.clk (clk),
		.rst (rst),
		.char_valid (char_valid),
		.char_code (char_code),
		.clear_valid (clear_valid),
		.push (push),
		.push_entry (push_entry)
	);

	lcd_cmd_fifo fifo0 (
		.clk (clk),
		.rst (rst),
		.push (push),
		.push_entry (push_entry),
		.cmd (cmd_bus.source),
		.overflow (overflow)
	);

	lcd_bus_driver driver0 (
		.clk (clk),
		.rst (rst),
		.disp_mode (disp_mode),
		.cmd (cmd_bus.sink),
		.lcd_e (lcd_e),
		.lcd_rs (lcd_rs),
		.lcd_rw (lcd_rw),
		.lcd_data (lcd_data),
		.ready (ready)
	);

endmodule

// File: sim/lcd_text_sva.sv
`timescale 1ns/1ps

module lcd_text_sva (
	input logic clk,
	input logic rst,
	input logic lcd_e,
	input logic lcd_rs,
	input logic lcd_rw,
	input logic [7:0] lcd_data,
	input logic ready
);

	localparam int XFER_E_CYC = lcd_pkg::T_E_HIGH_US * lcd_pkg::CYC_PER_US;
	localparam int INIT_E_CYC = lcd_pkg::T_INIT_E_US * lcd_pkg::CYC_PER_US;

	int e_high_cnt;	// cycles of the current e pulse
	int e_width;

	assign e_width = ready ? XFER_E_CYC : INIT_E_CYC;	// init pulses are shorter

	always_ff @(posedge clk) begin
		if (rst) begin
			e_high_cnt <= 0;
		end else if (lcd_e) begin
			e_high_cnt <= e_high_cnt + 1;
		end else begin
			e_high_cnt <= 0;
		end
	end

	e_width_a: assert property (@(posedge clk) disable iff (rst)
		$fell(lcd_e) |-> (e_high_cnt == e_width))
		else $error("lcd_e high period has the wrong length");

	rw_low_a: assert property (@(posedge clk) disable iff (rst) !lcd_rw)
		else $error("lcd_rw went high on a write-only bus");

	// the display latches on the falling edge
	bus_stable_a: assert property (@(posedge clk) disable iff (rst)
		lcd_e |=> (!lcd_e || ($stable(lcd_rs) && $stable(lcd_data))))
		else $error("lcd_rs or lcd_data changed while lcd_e was high");

	ready_hold_a: assert property (@(posedge clk) disable iff (rst) ready |=> ready)
		else $error("ready fell after initialization");

endmodule

// File: sim/lcd_text_tb.sv
`timescale 1ns/1ps

module lcd_text_tb;

	localparam int READY_TIMEOUT = 20000;	// cycles
	localparam int DRAIN_TIMEOUT = 40000;
	localparam int QUIET_CYC = 3200;	// longer than any e-low gap in a clear slot
	localparam int BURST_LEN = lcd_pkg::FIFO_DEPTH + 4;
	localparam logic [6:0] MODE = 7'b1011010;	// 2 lines, 5x8, display+cursor on, increment

	logic clk = 1'b0;
	logic rst;
	logic char_valid;
	logic [7:0] char_code;
	logic clear_valid;
	logic [6:0] disp_mode;
	logic lcd_e;
	logic lcd_rs;
	logic lcd_rw;
	logic [7:0] lcd_data;
	logic ready;
	logic overflow;

	logic [8:0] exp_q [$];	// {rs, data} in bus order
	int errors = 0;
	int checks = 0;
	int xfers = 0;	// falling edges of lcd_e
	logic e_prev = 1'b0;
	logic [16:0] lfsr = 17'd66561;
	int m_col = 0;	// reference cursor
	int m_row = 0;
	bit m_need_addr = 1'b0;

	lcd_text_top dut0 (
		.clk (clk),
		.rst (rst),
		.char_valid (char_valid),
		.char_code (char_code),
		.clear_valid (clear_valid),
		.disp_mode (disp_mode),
		.lcd_e (lcd_e),
		.lcd_rs (lcd_rs),
		.lcd_rw (lcd_rw),
		.lcd_data (lcd_data),
		.ready (ready),
		.overflow (overflow)
	);

	bind lcd_bus_driver lcd_text_sva sva0 (
		.clk (clk),
		.rst (rst),
		.lcd_e (lcd_e),
		.lcd_rs (lcd_rs),
		.lcd_rw (lcd_rw),
		.lcd_data (lcd_data),
		.ready (ready)
	);

	always #4 clk = ~clk;

	// x^17 + x^14 + 1
	function automatic logic [16:0] lfsr_next(input logic [16:0] s);
		return {s[15:0], s[16] ^ s[13]};
	endfunction

	task automatic rand_bits(input int n, output logic [7:0] val);
		val = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr);
			val = {val[6:0], lfsr[0]};
		end
	endtask

	task automatic check_value(input string name, input logic [7:0] got, input logic [7:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("** Error at %0t ns: %s = 0x%02h, expected 0x%02h", $time, name, got, exp);
		end
	endtask

	task automatic check_true(input logic cond, input string what);
		checks++;
		assert (cond) else begin
			errors++;
			$display("Check failed at %0t ns: %s", $time, what);
		end
	endtask

	task automatic finish_run();
		$display("%0d checks, %0d errors, %0d bus transfers", checks, errors, xfers);
		if (errors == 0) begin
			$display("TESTBENCH PASSED");
		end else begin
			$display("TESTBENCH FAILED");
		end
		$finish;
	endtask

	task automatic abort_run(input string what);
		errors++;
		$display("Timeout at %0t ns: %s", $time, what);
		finish_run();
	endtask

	// display latches rs and data when e falls
	always @(negedge clk) begin
		if (e_prev === 1'b1 && lcd_e === 1'b0) begin
			xfers++;
			if (exp_q.size() == 0) begin
				check_true(1'b0, "transfer on the bus with nothing expected");
			end else begin
				check_value("lcd_rs", {7'b0, lcd_rs}, {7'b0, exp_q[0][8]});
				check_value("lcd_data", lcd_data, exp_q[0][7:0]);
				exp_q.delete(0);
			end
		end
		e_prev = lcd_e;
	end

	task automatic model_char(input logic [7:0] code);
		logic [7:0] line_start;
		line_start = (m_row == 0) ? 8'h00 : {1'b0, lcd_pkg::LINE2_ADDR};
		if (m_need_addr) begin	// address command first after a wrap
			exp_q.push_back({1'b0, lcd_pkg::CMD_SET_ADDR | line_start});
		end
		exp_q.push_back({1'b1, code});
		if (m_col == lcd_pkg::COLS - 1) begin
			m_col = 0;
			m_row = (m_row + 1) % lcd_pkg::ROWS;
			m_need_addr = 1'b1;
		end else begin
			m_col++;
			m_need_addr = 1'b0;
		end
	endtask

	task automatic model_clear();
		exp_q.push_back({1'b0, lcd_pkg::CMD_CLEAR});
		m_col = 0;
		m_row = 0;
		m_need_addr = 1'b0;	// display homes itself
	endtask

	task automatic wait_ready();
		int n = 0;
		while (ready !== 1'b1 && n < READY_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (ready !== 1'b1) begin
			abort_run("ready did not rise after initialization");
		end
	endtask

	task automatic wait_drained();
		int n = 0;
		while (exp_q.size() != 0 && n < DRAIN_TIMEOUT) begin
			@(negedge clk);
			n++;
		end
		if (exp_q.size() != 0) begin
			abort_run("expected transfers never appeared on the bus");
		end
	endtask

	task automatic wait_quiet();
		int n = 0;
		int low = 0;
		while (low < QUIET_CYC && n < DRAIN_TIMEOUT) begin
			@(negedge clk);
			n++;
			if (lcd_e === 1'b0) begin
				low++;
			end else begin
				low = 0;
			end
		end
		if (low < QUIET_CYC) begin
			abort_run("lcd_e kept toggling after the burst");
		end
	endtask

	task automatic send_char(input logic [7:0] code);
		@(posedge clk);
		char_valid <= 1'b1;
		char_code <= code;
		model_char(code);
		@(posedge clk);
		char_valid <= 1'b0;
	endtask

	task automatic send_clear(input logic with_char);
		@(posedge clk);
		clear_valid <= 1'b1;
		char_valid <= with_char;
		char_code <= 8'h5a;	// dropped because clear wins
		model_clear();
		@(posedge clk);
		clear_valid <= 1'b0;
		char_valid <= 1'b0;
	endtask

	// random gaps keep the queue well below full
	task automatic send_chars(input int n);
		logic [7:0] code;
		logic [7:0] gap;
		for (int i = 0; i < n; i++) begin
			rand_bits(8, code);
			send_char(code);
			rand_bits(4, gap);
			repeat (int'(gap)) @(posedge clk);
			if ((i % 8) == 7) begin
				wait_drained();
			end
		end
		wait_drained();
	endtask

	task automatic send_burst(input int n);
		logic [7:0] code;
		for (int i = 0; i < n; i++) begin
			rand_bits(8, code);
			@(posedge clk);
			char_valid <= 1'b1;
			char_code <= code;
			model_char(code);
		end
		@(posedge clk);
		char_valid <= 1'b0;
	endtask

	initial begin
		int burst_start;
		rst <= 1'b1;
		char_valid <= 1'b0;
		char_code <= 8'h00;
		clear_valid <= 1'b0;
		disp_mode <= MODE;
		// power-up command sequence
		exp_q.push_back({1'b0, 8'h30 | {4'b0, MODE[6:5], 2'b00}});
		exp_q.push_back({1'b0, 8'h08 | {5'b0, MODE[4:2]}});
		exp_q.push_back({1'b0, lcd_pkg::CMD_CLEAR});
		exp_q.push_back({1'b0, 8'h04 | {6'b0, MODE[1:0]}});
		repeat (2) @(posedge clk);
		@(negedge clk);
		check_value("lcd_e", {7'b0, lcd_e}, 8'h00);
		check_value("lcd_rs", {7'b0, lcd_rs}, 8'h00);
		check_value("lcd_rw", {7'b0, lcd_rw}, 8'h00);
		check_value("lcd_data", lcd_data, 8'h00);
		check_value("ready", {7'b0, ready}, 8'h00);
		check_value("overflow", {7'b0, overflow}, 8'h00);
		@(posedge clk);
		rst <= 1'b0;	// third reset cycle ends here

		wait_ready();
		check_value("init transfers", xfers[7:0], 8'd4);

		send_chars(48);	// ends right after a wrap with an address pending
		check_true(!overflow, "overflow set without a burst");
		send_clear(1'b0);
		send_chars(20);	// wrap count starts over after the clear
		send_clear(1'b1);
		wait_drained();

		burst_start = xfers;
		send_burst(BURST_LEN);
		wait_quiet();
		check_true(overflow === 1'b1, "overflow not set by the burst");
		check_true(xfers - burst_start >= lcd_pkg::FIFO_DEPTH,
			"burst delivered fewer bytes than the queue depth");
		@(posedge clk);
		exp_q.delete();	// dropped entries never reach the bus
		finish_run();
	end

endmodule

// File: sources.f
rtl/lcd_pkg.sv
rtl/lcd_cmd_if.sv
rtl/lcd_cursor_tracker.sv
rtl/lcd_cmd_fifo.sv
rtl/lcd_bus_driver.sv
rtl/lcd_text_top.sv
sim/lcd_text_sva.sv
sim/lcd_text_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the display controller testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
	--top-module lcd_text_tb \
	-f sources.f \
	-o lcd_text_sim

if ! out=$(./obj_dir/lcd_text_sim 2>&1); then
	echo "$out"
	echo "simulation exited with an error"
	exit 1
fi
echo "$out"

if echo "$out" | grep -q "TESTBENCH PASSED"; then
	exit 0
fi
exit 1
